/* snes_load_pkg.sv */
/*
 * Shared definitions for the cartridge loading path
 *   - header option and work RAM pattern enums
 *   - internal header base addresses and field offsets
 *   - download index values, default sizes and fill bytes
 */

`default_nettype none

package snes_load_pkg;

	// ========================================
	// Option encodings
	// ========================================

	// ROM header handling selected by the user
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} rom_header_mode_e;

	// Power-on content of work RAM
	typedef enum logic [1:0] {
		PAT_9966 = 2'd0,
		PAT_00FF = 2'd1,
		PAT_55   = 2'd2,
		PAT_FF   = 2'd3
	} wram_pattern_e;

	// ========================================
	// Header layout
	// ========================================

	// Copier header in front of the image
	localparam logic [15:0] COPIER_HEADER_BYTES = 16'd512;

	localparam logic [23:0] LOROM_HDR_BASE   = 24'h007FC0;
	localparam logic [23:0] HIROM_HDR_BASE   = 24'h00FFC0;
	localparam logic [23:0] EXHIROM_HDR_BASE = 24'h40FFC0;

	// Size byte sits in the high half of the word at 16h
	localparam logic [7:0] HDR_SIZE_OFS = 8'h16;
	localparam logic [7:0] HDR_RAM_OFS  = 8'h18;

	// ========================================
	// Download stream
	// ========================================

	localparam logic [7:0] IDX_CART  = 8'h00;
	localparam logic [7:0] IDX_CHEAT = 8'hFF;

	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'hC;
	localparam logic [23:0] MASK_UNIT        = 24'd1024;

	// Fill bytes
	localparam logic [7:0] PAT_BYTE_66 = 8'h66;
	localparam logic [7:0] PAT_BYTE_99 = 8'h99;
	localparam logic [7:0] PAT_BYTE_55 = 8'h55;
	localparam logic [7:0] PAT_BYTE_FF = 8'hFF;
	localparam logic [7:0] PAT_BYTE_00 = 8'h00;

endpackage

`default_nettype wire

/* rom_header_detect.sv */
/*
 * ROM header detection
 *   - size and type capture from the download stream
 *   - ROM and RAM address mask derivation
 *   - region latch and video region select
 */

`timescale 1ns/1ps
`default_nettype none

module rom_header_detect (
	input  wire                             clk_sys,
	input  wire                             RESET,
	input  wire                             cart_download,
	input  wire                             ioctl_wr,
	input  wire [24:0]                      ioctl_addr,
	input  wire [15:0]                      ioctl_dout,
	input  wire snes_load_pkg::rom_header_mode_e header_mode,
	input  wire [1:0]                       region_sel,
	output logic [7:0]                      rom_type,
	output logic [23:0]                     rom_mask,
	output logic [23:0]                     ram_mask,
	output logic                            pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        fixed_mode;
	logic [23:0] hdr_base;
	logic [24:0] size_addr;
	logic [24:0] ram_addr;
	logic        hdr_wr;

	assign hdr_wr = cart_download & ioctl_wr;

	// Internal header location for the forced modes
	always_comb begin
		fixed_mode = 1'b1;
		case (header_mode)
			snes_load_pkg::HDR_LOROM:   hdr_base = snes_load_pkg::LOROM_HDR_BASE;
			snes_load_pkg::HDR_HIROM:   hdr_base = snes_load_pkg::HIROM_HDR_BASE;
			snes_load_pkg::HDR_EXHIROM: hdr_base = snes_load_pkg::EXHIROM_HDR_BASE;
			default: begin
				hdr_base   = '0;
				fixed_mode = 1'b0;
			end
		endcase
	end

	// Header fields sit behind the copier header
	assign size_addr = {1'b0, hdr_base} + 25'(snes_load_pkg::HDR_SIZE_OFS)
		+ 25'(snes_load_pkg::COPIER_HEADER_BYTES);
	assign ram_addr = {1'b0, hdr_base} + 25'(snes_load_pkg::HDR_RAM_OFS)
		+ 25'(snes_load_pkg::COPIER_HEADER_BYTES);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == 25'd0) begin
				rom_size <= snes_load_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Loader packs both size codes into the first byte
				if (header_mode == snes_load_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
					ram_size <= ioctl_dout[7:4];
					rom_size <= ioctl_dout[3:0];
				end
				case (header_mode)
					snes_load_pkg::HDR_NONE,
					snes_load_pkg::HDR_LOROM:   rom_type <= 8'd0;
					snes_load_pkg::HDR_HIROM:   rom_type <= 8'd1;
					snes_load_pkg::HDR_EXHIROM: rom_type <= 8'd2;
					default:                    rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == 25'd2)
				rom_region <= ioctl_dout[8];
			if (fixed_mode && ioctl_addr == size_addr)
				rom_size <= ioctl_dout[11:8];
			if (fixed_mode && ioctl_addr == ram_addr)
				ram_size <= ioctl_dout[3:0];
		end
	end

	// Masks from size codes, zero RAM code means no RAM
	assign rom_mask = (snes_load_pkg::MASK_UNIT << rom_size) - 24'd1;
	assign ram_mask = (ram_size == 4'd0) ? 24'd0
		: (snes_load_pkg::MASK_UNIT << ram_size) - 24'd1;

	// Region only follows the user setting outside downloads
	always_ff @(posedge clk_sys) begin
		if (RESET)
			pal <= 1'b0;
		else if (!cart_download)
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
	end

endmodule

`default_nettype wire

/* cheat_code_assembler.sv */
/*
 * Cheat code assembly
 *   - eight 16-bit download words into one 128-bit code
 *   - one-cycle strobe when the last word lands
 */

`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire          clk_sys,
	input  wire          RESET,
	input  wire          code_download,
	input  wire          ioctl_wr,
	input  wire [3:0]    ioctl_addr,
	input  wire [15:0]   ioctl_dout,
	output logic [127:0] cheat_code,
	output logic         cheat_valid
);

	logic code_wr;

	assign code_wr = code_download & ioctl_wr;

	// ========================================
	// Code layout, words in big-endian order
	// flags 127:96, address 95:64
	// compare 63:32, replace 31:0
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_code  <= '0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= 1'b0;
			if (code_wr) begin
				case (ioctl_addr)
					4'd0:  cheat_code[111:96]  <= ioctl_dout;
					4'd2:  cheat_code[127:112] <= ioctl_dout;
					4'd4:  cheat_code[79:64]   <= ioctl_dout;
					4'd6:  cheat_code[95:80]   <= ioctl_dout;
					4'd8:  cheat_code[47:32]   <= ioctl_dout;
					4'd10: cheat_code[63:48]   <= ioctl_dout;
					4'd12: cheat_code[15:0]    <= ioctl_dout;
					4'd14: begin
						// Last word completes the code
						cheat_code[31:16] <= ioctl_dout;
						cheat_valid       <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* wram_clear_fill.sv */
/*
 * Work RAM clear on cartridge load
 *   - download start detect and fill address sequencer
 *   - power-on pattern generator
 */

`timescale 1ns/1ps
`default_nettype none

module wram_clear_fill #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  wire                             clk_sys,
	input  wire                             RESET,
	input  wire                             cart_download,
	input  wire snes_load_pkg::wram_pattern_e wram_init,
	output logic                            clearing_ram,
	output logic [FILL_ADDR_BITS-1:0]       fill_addr,
	output logic [7:0]                      fill_data,
	output logic                            fill_we
);

	logic old_download;
	logic fill_start;
	logic fill_done;

	assign fill_start = cart_download & ~old_download;
	assign fill_done  = clearing_ram & (&fill_addr);

	// ========================================
	// Address sequencer
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			clearing_ram <= 1'b0;
			fill_addr    <= '0;
		end else begin
			old_download <= cart_download;
			if (fill_start)
				clearing_ram <= 1'b1;
			else if (fill_done)
				clearing_ram <= 1'b0;
			// Counter parks at zero between fills
			if (clearing_ram)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	assign fill_we = clearing_ram;

	// Pattern as a function of the address
	always_comb begin
		case (wram_init)
			snes_load_pkg::PAT_9966:
				fill_data = (fill_addr[8] ^ fill_addr[2]) ? snes_load_pkg::PAT_BYTE_66
					: snes_load_pkg::PAT_BYTE_99;
			snes_load_pkg::PAT_00FF:
				fill_data = (fill_addr[9] ^ fill_addr[0]) ? snes_load_pkg::PAT_BYTE_FF
					: snes_load_pkg::PAT_BYTE_00;
			snes_load_pkg::PAT_55:
				fill_data = snes_load_pkg::PAT_BYTE_55;
			default:
				fill_data = snes_load_pkg::PAT_BYTE_FF;
		endcase
	end

endmodule

`default_nettype wire

/* cart_loader_top.sv */
/*
 * Cartridge loading path top level
 *   - download kind decode from the loader index
 *   - header detect, cheat assembly and work RAM fill
 */

`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  wire                               clk_sys,
	input  wire                               RESET,
	input  wire                               ioctl_download,
	input  wire [7:0]                         ioctl_index,
	input  wire [24:0]                        ioctl_addr,
	input  wire [15:0]                        ioctl_dout,
	input  wire                               ioctl_wr,
	input  wire snes_load_pkg::rom_header_mode_e header_mode,
	input  wire [1:0]                         region_sel,
	input  wire snes_load_pkg::wram_pattern_e wram_init,
	output logic [7:0]                        rom_type,
	output logic [23:0]                       rom_mask,
	output logic [23:0]                       ram_mask,
	output logic                              pal,
	output logic [127:0]                      cheat_code,
	output logic                              cheat_valid,
	output logic                              clearing_ram,
	output logic [FILL_ADDR_BITS-1:0]         fill_addr,
	output logic [7:0]                        fill_data,
	output logic                              fill_we
);

	logic cart_download;
	logic code_download;

	// Cartridge images use any index with the low six bits clear
	assign cart_download = ioctl_download
		& (ioctl_index[5:0] == snes_load_pkg::IDX_CART[5:0]);
	assign code_download = ioctl_download & (ioctl_index == snes_load_pkg::IDX_CHEAT);

	// ========================================
	// Loader consumers
	// ========================================
	rom_header_detect i_header (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	// Word offset within a code record
	cheat_code_assembler i_cheat (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr[3:0]),
		.ioctl_dout    (ioctl_dout),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid)
	);

	wram_clear_fill #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) i_fill (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.wram_init     (wram_init),
		.clearing_ram  (clearing_ram),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data),
		.fill_we       (fill_we)
	);

endmodule

`default_nettype wire

/* tb_cart_loader.sv */
/*
 * Testbench for the cartridge loading path
 *   - clock, reset, run limit and LFSR stimulus
 *   - reference models and compare tasks
 *   - fill, header, region and cheat tests with summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;

	localparam int FILL_BITS   = 17;
	localparam int FILL_LEN    = 1 << FILL_BITS;
	// Four full fills plus margin for the short tests
	localparam int CYCLE_LIMIT = 560000;

	logic                 clk_sys;
	logic                 RESET;
	logic                 ioctl_download;
	logic                 ioctl_wr;
	logic [7:0]           ioctl_index;
	logic [24:0]          ioctl_addr;
	logic [15:0]          ioctl_dout;
	logic [1:0]           region_sel;
	snes_load_pkg::rom_header_mode_e header_mode;
	snes_load_pkg::wram_pattern_e    wram_init;
	logic [7:0]           rom_type;
	logic [23:0]          rom_mask;
	logic [23:0]          ram_mask;
	logic                 pal;
	logic [127:0]         cheat_code;
	logic                 cheat_valid;
	logic                 clearing_ram;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0]           fill_data;
	logic                 fill_we;
	logic [15:0]          lfsr_state;
	int                   errors;
	int                   tests;
	int                   failed;
	int                   test_start;
	int                   cycles;

	cart_loader_top #(.FILL_ADDR_BITS(FILL_BITS)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles, a test did not finish", cycles);
		$display("Errors found");
		$finish;
	end

	// ========================================
	// Stimulus source and reference models
	// ========================================

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[14:0], lfsr_state[0]};
		end
	endtask

	// Size code counts doublings of 1 KiB
	function automatic logic [23:0] ref_rom_mask(input logic [3:0] code);
		logic [31:0] span;
		span = 32'd1 << (32'(code) + 32'd10);
		return 24'(span - 32'd1);
	endfunction

	function automatic logic [23:0] ref_ram_mask(input logic [3:0] code);
		return (code == 4'd0) ? 24'd0 : ref_rom_mask(code);
	endfunction

	function automatic logic [7:0] ref_rom_type(input snes_load_pkg::rom_header_mode_e mode,
		input logic [7:0] hi);
		case (mode)
			snes_load_pkg::HDR_HIROM:   return 8'd1;
			snes_load_pkg::HDR_EXHIROM: return 8'd2;
			snes_load_pkg::HDR_AUTO:    return hi;
			default:                    return 8'd0;
		endcase
	endfunction

	function automatic logic ref_pal(input logic [1:0] sel, input logic latched);
		return (sel == 2'd0) ? latched : sel[1];
	endfunction

	// Word k lands at offset 2k and word pairs swap inside each 32-bit field
	function automatic logic [127:0] ref_cheat(input logic [7:0][15:0] w);
		return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
	endfunction

	function automatic logic [7:0] ref_fill(input logic [FILL_BITS-1:0] a,
		input snes_load_pkg::wram_pattern_e pat);
		case (pat)
			snes_load_pkg::PAT_9966: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			snes_load_pkg::PAT_00FF: return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			snes_load_pkg::PAT_55:   return 8'h55;
			default:                 return 8'hFF;
		endcase
	endfunction

	// ========================================
	// Compare tasks
	// ========================================
	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	task automatic check_rom_info(input logic [23:0] exp_rom, input logic [23:0] exp_ram,
		input logic [7:0] exp_type);
		if (rom_mask !== exp_rom)
			report_mismatch("rom_mask", 128'(rom_mask), 128'(exp_rom));
		if (ram_mask !== exp_ram)
			report_mismatch("ram_mask", 128'(ram_mask), 128'(exp_ram));
		if (rom_type !== exp_type)
			report_mismatch("rom_type", 128'(rom_type), 128'(exp_type));
	endtask

	task automatic check_pal(input logic exp);
		if (pal !== exp)
			report_mismatch("pal", 128'(pal), 128'(exp));
	endtask

	task automatic check_cheat(input logic [127:0] exp);
		if (cheat_code !== exp)
			report_mismatch("cheat_code", cheat_code, exp);
	endtask

	task automatic check_fill(input logic [7:0] got, input snes_load_pkg::wram_pattern_e pat,
		input logic [FILL_BITS-1:0] addr);
		logic [7:0] exp;
		exp = ref_fill(addr, pat);
		if (got !== exp)
			report_mismatch("fill_data", 128'(got), 128'(exp));
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != test_start) begin
			failed++;
			$display("test %s: FAIL", name);
		end else
			$display("test %s: pass", name);
		test_start = errors;
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic fill_test(input snes_load_pkg::wram_pattern_e pat);
		int wait_cycles;
		int count;
		wait_cycles = 0;
		count = 0;
		@(negedge clk_sys);
		wram_init      = pat;
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		do begin
			@(negedge clk_sys);
			wait_cycles++;
		end while (!fill_we && wait_cycles < 4);
		if (wait_cycles != 1) begin
			$display("Fill did not start one cycle after the download began");
			errors++;
		end
		while (fill_we && count <= FILL_LEN) begin
			if (fill_addr !== FILL_BITS'(count))
				report_mismatch("fill_addr", 128'(fill_addr), 128'(count));
			check_fill(fill_data, pat, FILL_BITS'(count));
			count++;
			@(negedge clk_sys);
		end
		if (count != FILL_LEN) begin
			$display("Fill length wrong, fill_we high for %0d cycles instead of %0d",
				count, FILL_LEN);
			errors++;
		end
		if (clearing_ram !== 1'b0)
			report_mismatch("clearing_ram", 128'(clearing_ram), 128'd0);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		finish_test($sformatf("fill %s", pat.name()));
	endtask

	task automatic auto_header_test();
		logic [15:0] word;
		@(negedge clk_sys);
		header_mode    = snes_load_pkg::HDR_AUTO;
		ioctl_index    = 8'h40;
		ioctl_download = 1'b1;
		take_bits(16, word);
		if (word[7:0] == 8'h00)
			word[7:0] = 8'h5A;
		write_word(25'd0, word);
		check_rom_info(ref_rom_mask(word[3:0]), ref_ram_mask(word[7:4]),
			ref_rom_type(snes_load_pkg::HDR_AUTO, word[15:8]));
		finish_test("header auto");
	endtask

	// Download stays open from the auto test
	task automatic fixed_header_test(input snes_load_pkg::rom_header_mode_e mode,
		input logic [23:0] base, input logic no_ram);
		logic [15:0] word;
		logic [3:0]  rom_code;
		logic [3:0]  ram_code;
		@(negedge clk_sys);
		header_mode = mode;
		take_bits(4, word);
		rom_code = word[3:0];
		take_bits(4, word);
		ram_code = no_ram ? 4'd0 : word[3:0];
		take_bits(16, word);
		write_word(25'd0, word);
		take_bits(16, word);
		write_word(25'(base) + 25'h16 + 25'd512, {word[15:12], rom_code, word[7:0]});
		take_bits(16, word);
		write_word(25'(base) + 25'h18 + 25'd512, {word[15:4], ram_code});
		check_rom_info(ref_rom_mask(rom_code), ref_ram_mask(ram_code),
			ref_rom_type(mode, 8'h00));
		finish_test($sformatf("header %s", mode.name()));
	endtask

	task automatic region_test();
		logic [15:0] word;
		take_bits(16, word);
		word[8] = 1'b1;
		write_word(25'd2, word);
		ioctl_download = 1'b0;
		for (int sel = 0; sel < 4; sel++) begin
			region_sel = 2'(sel);
			@(negedge clk_sys);
			check_pal(ref_pal(2'(sel), 1'b1));
		end
		finish_test("region");
	endtask

	task automatic cheat_test(input string name);
		logic [7:0][15:0] words;
		logic [15:0]      word;
		int               pulses;
		pulses = 0;
		@(negedge clk_sys);
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		for (int k = 0; k < 8; k++) begin
			take_bits(16, word);
			words[k] = word;
			write_word(25'(2 * k), word);
			if (cheat_valid)
				pulses++;
		end
		// Watch a few more cycles for a stray second pulse
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			if (cheat_valid)
				pulses++;
		end
		if (pulses == 0) begin
			$display("cheat_valid pulse never arrived after the last code word");
			errors++;
		end else if (pulses > 1) begin
			$display("Saw %0d cheat_valid pulses for one code", pulses);
			errors++;
		end
		check_cheat(ref_cheat(words));
		ioctl_download = 1'b0;
		finish_test(name);
	endtask

	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		region_sel     = 2'd0;
		header_mode    = snes_load_pkg::HDR_AUTO;
		wram_init      = snes_load_pkg::PAT_9966;
		lfsr_state     = 16'd13540;
		errors         = 0;
		tests          = 0;
		failed         = 0;
		test_start     = 0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;

		for (int p = 0; p < 4; p++)
			fill_test(snes_load_pkg::wram_pattern_e'(p));
		auto_header_test();
		fixed_header_test(snes_load_pkg::HDR_LOROM, 24'h007FC0, 1'b0);
		fixed_header_test(snes_load_pkg::HDR_HIROM, 24'h00FFC0, 1'b0);
		fixed_header_test(snes_load_pkg::HDR_EXHIROM, 24'h40FFC0, 1'b1);
		region_test();
		cheat_test("cheat first");
		cheat_test("cheat second");

		$display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
snes_load_pkg.sv
rom_header_detect.sv
cheat_code_assembler.sv
wram_clear_fill.sv
cart_loader_top.sv
tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the cartridge loader testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_cart_loader -f src.f \
	--Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or run failed"; exit 1; }

grep -qx "No errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
